// ==== i2c_pkg.sv ====
package i2c_pkg;

    // APB register offsets.
    localparam logic [7:0] reg_prescale = 8'h00;
    localparam logic [7:0] reg_cmd      = 8'h04;
    localparam logic [7:0] reg_status   = 8'h08;
    localparam logic [7:0] reg_txdata   = 8'h0C;
    localparam logic [7:0] reg_rxdata   = 8'h10;
    localparam logic [7:0] reg_addr     = 8'h14;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [7:0] paddr;
        logic [7:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic       go;     // Self-clearing start.
        logic       rw;     // 1 = read.
        logic       flush;  // Empties both FIFOs.
        logic [3:0] count;
        logic       rsvd;
    } i2c_cmd_t;

    typedef struct packed {
        logic       busy;
        logic       nack;
        logic       tx_full;
        logic       tx_empty;
        logic       rx_full;
        logic       rx_empty;
        logic [1:0] rsvd;
    } i2c_status_t;

    // Same byte seen as raw data or as the address byte.
    typedef union packed {
        logic [7:0] data;
        struct packed {
            logic [6:0] addr;
            logic       rw;
        } addr_rw;
    } i2c_byte_u;

    // Quarters of one SCL bit.
    typedef enum logic [1:0] {
        ph_low0  = 2'd0,
        ph_low1  = 2'd1,
        ph_high0 = 2'd2,
        ph_high1 = 2'd3
    } bit_phase_t;

endpackage

// ==== i2c_fifo.sv ====
`timescale 1ns/1ns

module i2c_fifo #(
    parameter int fifo_aw = 3
) (
    input  logic       pclk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       push,
    input  logic [7:0] wdata,
    input  logic       pop,
    output logic [7:0] rdata,
    output logic       full,
    output logic       empty
);
    logic [7:0]       mem [2**fifo_aw];
    logic [fifo_aw:0] wr_ptr;
    logic [fifo_aw:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Extra pointer bit tells full from empty.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[fifo_aw] != rd_ptr[fifo_aw]) &&
                   (wr_ptr[fifo_aw-1:0] == rd_ptr[fifo_aw-1:0]);
    assign rdata = mem[rd_ptr[fifo_aw-1:0]];  // Head shown first-word-through.

    always_ff @(posedge pclk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge pclk) begin
        if (do_push) mem[wr_ptr[fifo_aw-1:0]] <= wdata;
    end

endmodule

// ==== i2c_scl_tick.sv ====
`timescale 1ns/1ns

module i2c_scl_tick (
    input  logic       pclk,
    input  logic       rst_n,
    input  logic       run,
    input  logic [7:0] prescale,
    output logic       tick
);
    logic [7:0] cnt;

    // One tick per quarter bit.
    assign tick = run && (cnt == 8'd0);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            cnt <= 8'd0;
        end else if (!run || cnt == 8'd0) begin
            cnt <= prescale;  // Idle holds at reload, fixed start phase.
        end else begin
            cnt <= cnt - 8'd1;
        end
    end

endmodule

// ==== i2c_apb_regs.sv ====
`timescale 1ns/1ns

module i2c_apb_regs (
    input  logic              pclk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [7:0]        paddr,
    input  logic [7:0]        pwdata,
    input  logic              busy,
    input  logic              nack,
    input  logic              tx_full,
    input  logic              tx_empty,
    input  logic              rx_full,
    input  logic              rx_empty,
    input  logic [7:0]        rx_rdata,
    output logic [7:0]        prdata,
    output logic              pready,
    output logic [7:0]        prescale,
    output logic [6:0]        slave_addr,
    output i2c_pkg::i2c_cmd_t cmd,
    output logic              tx_push,
    output logic [7:0]        tx_wdata,
    output logic              rx_pop
);
    import i2c_pkg::*;

    apb_req_t    req;
    i2c_cmd_t    wcmd;
    i2c_status_t status;
    logic        wr;
    logic        rd;
    logic        cmd_wr;
    logic        rw_q;
    logic [3:0]  count_q;

    assign req = '{psel: psel, penable: penable, pwrite: pwrite,
                   paddr: paddr, pwdata: pwdata};

    assign wr     = req.psel && req.penable && req.pwrite;   // Access phase only.
    assign rd     = req.psel && req.penable && !req.pwrite;
    assign cmd_wr = wr && (req.paddr == reg_cmd);
    assign wcmd   = i2c_cmd_t'(req.pwdata);

    assign pready = 1'b1;  // No wait states.

    assign tx_push  = wr && (req.paddr == reg_txdata);
    assign tx_wdata = req.pwdata;
    assign rx_pop   = rd && (req.paddr == reg_rxdata) && !rx_empty;

    // Go and flush are pulses in the access cycle, so busy follows one cycle later.
    always_comb begin
        cmd.go    = cmd_wr && wcmd.go && !busy;
        cmd.flush = cmd_wr && wcmd.flush;
        cmd.rw    = (cmd_wr && !busy) ? wcmd.rw : rw_q;
        cmd.count = (cmd_wr && !busy) ? wcmd.count : count_q;
        cmd.rsvd  = 1'b0;
    end

    assign status = '{busy: busy, nack: nack, tx_full: tx_full, tx_empty: tx_empty,
                      rx_full: rx_full, rx_empty: rx_empty, rsvd: 2'b00};

    always_comb begin
        prdata = 8'h00;
        if (rd) begin
            case (req.paddr)
                reg_prescale: prdata = prescale;
                reg_cmd:      prdata = i2c_cmd_t'{go: 1'b0, rw: rw_q, flush: 1'b0,
                                                  count: count_q, rsvd: 1'b0};
                reg_status:   prdata = status;
                reg_rxdata:   prdata = rx_rdata;  // Value being popped.
                reg_addr:     prdata = {1'b0, slave_addr};
                default:      prdata = 8'h00;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            prescale   <= 8'h00;
            slave_addr <= 7'h00;
            rw_q       <= 1'b0;
            count_q    <= 4'h0;
        end else if (wr) begin
            case (req.paddr)
                reg_prescale: prescale <= req.pwdata;
                reg_addr:     slave_addr <= req.pwdata[6:0];
                reg_cmd: begin
                    if (!busy) begin
                        rw_q    <= wcmd.rw;
                        count_q <= wcmd.count;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== i2c_master_ctrl.sv ====
`timescale 1ns/1ns

module i2c_master_ctrl (
    input  logic              pclk,
    input  logic              rst_n,
    input  logic              tick,
    input  i2c_pkg::i2c_cmd_t cmd,
    input  logic [6:0]        slave_addr,
    input  logic [7:0]        tx_rdata,
    input  logic              tx_empty,
    input  logic              rx_full,
    input  logic              sda_in,
    output logic              tx_pop,
    output logic              rx_push,
    output logic [7:0]        rx_wdata,
    output logic              busy,
    output logic              nack,
    output logic              scl_out,
    output logic              sda_out
);
    import i2c_pkg::*;

    typedef enum logic [2:0] {
        st_idle, st_start, st_addr, st_ack, st_write, st_read, st_mack, st_stop
    } state_t;

    state_t     state;
    bit_phase_t phase;
    i2c_byte_u  sh;
    logic [2:0] bit_cnt;
    logic [3:0] bytes_left;
    logic       rw_q;
    logic       byte_start;
    logic       stall;
    logic       step;
    logic       bit_end;

    assign byte_start = (phase == ph_low0) && (bit_cnt == 3'd7);
    // Wait with SCL low until the FIFO can take part.
    assign stall   = byte_start && ((state == st_write && tx_empty) ||
                                    (state == st_read && rx_full));
    assign step    = tick && !stall;
    assign bit_end = step && (phase == ph_high1);

    assign tx_pop   = step && (state == st_write) && byte_start;
    assign rx_push  = bit_end && (state == st_read) && (bit_cnt == 3'd0);
    assign rx_wdata = {sh.data[6:0], sda_in};

    assign busy    = (state != st_idle);
    assign scl_out = (state == st_idle) || (state == st_start) ||
                     (phase == ph_high0) || (phase == ph_high1);

    // Shift word, address view at go, data view afterwards.
    always_ff @(posedge pclk) begin
        if (state == st_idle && cmd.go) begin
            sh.addr_rw.addr <= slave_addr;
            sh.addr_rw.rw   <= cmd.rw;
        end else if (tx_pop) begin
            sh.data <= tx_rdata;
        end else if (bit_end && (state == st_addr || state == st_write)) begin
            sh.data <= {sh.data[6:0], 1'b0};  // MSB first.
        end else if (bit_end && state == st_read) begin
            sh.data <= rx_wdata;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state      <= st_idle;
            phase      <= ph_low0;
            bit_cnt    <= 3'd7;
            bytes_left <= 4'd0;
            rw_q       <= 1'b0;
            nack       <= 1'b0;
            sda_out    <= 1'b1;
        end else if (state == st_idle) begin
            phase   <= ph_low0;
            sda_out <= 1'b1;
            if (cmd.go) begin
                state      <= st_start;
                nack       <= 1'b0;
                rw_q       <= cmd.rw;
                bytes_left <= cmd.count;
                bit_cnt    <= 3'd7;
            end
        end else if (step) begin
            phase <= bit_phase_t'(phase + 2'd1);
            case (state)
                st_start: begin
                    if (phase == ph_low1) sda_out <= 1'b0;  // SDA falls, SCL high.
                    if (phase == ph_high1) state <= st_addr;
                end
                st_addr, st_write: begin
                    if (phase == ph_low0) sda_out <= tx_pop ? tx_rdata[7] : sh.data[7];
                    if (phase == ph_high1) begin
                        bit_cnt <= bit_cnt - 3'd1;  // Wraps to 7 for the next byte.
                        if (bit_cnt == 3'd0) begin
                            state <= st_ack;
                            if (state == st_write) bytes_left <= bytes_left - 4'd1;
                        end
                    end
                end
                st_ack: begin
                    if (phase == ph_low0) sda_out <= 1'b1;
                    if (phase == ph_high1) begin
                        if (sda_in) begin
                            nack  <= 1'b1;
                            state <= st_stop;
                        end else if (bytes_left == 4'd0) begin
                            state <= st_stop;
                        end else begin
                            state <= rw_q ? st_read : st_write;
                        end
                    end
                end
                st_read: begin
                    if (phase == ph_low0) sda_out <= 1'b1;
                    if (phase == ph_high1) begin
                        bit_cnt <= bit_cnt - 3'd1;
                        if (bit_cnt == 3'd0) begin
                            state      <= st_mack;
                            bytes_left <= bytes_left - 4'd1;
                        end
                    end
                end
                st_mack: begin
                    // NACK the last byte.
                    if (phase == ph_low0) sda_out <= (bytes_left == 4'd0);
                    if (phase == ph_high1) state <= (bytes_left == 4'd0) ? st_stop : st_read;
                end
                st_stop: begin
                    if (phase == ph_low0) sda_out <= 1'b0;
                    if (phase == ph_high0) sda_out <= 1'b1;  // SDA rises, SCL high.
                    if (phase == ph_high1) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== i2c_master_top.sv ====
`timescale 1ns/1ns

module i2c_master_top #(
    parameter int fifo_aw = 3
) (
    input  logic       pclk,
    input  logic       rst_n,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [7:0] paddr,
    input  logic [7:0] pwdata,
    input  logic       sda_in,
    output logic [7:0] prdata,
    output logic       pready,
    output logic       scl_out,
    output logic       sda_out
);
    import i2c_pkg::*;

    i2c_cmd_t   cmd;
    logic [7:0] prescale;
    logic [6:0] slave_addr;
    logic       tick;
    logic       busy;
    logic       nack;

    logic       tx_push;
    logic       tx_pop;
    logic [7:0] tx_wdata;
    logic [7:0] tx_rdata;
    logic       tx_full;
    logic       tx_empty;

    logic       rx_push;
    logic       rx_pop;
    logic [7:0] rx_wdata;
    logic [7:0] rx_rdata;
    logic       rx_full;
    logic       rx_empty;

    i2c_apb_regs regs (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .busy       (busy),
        .nack       (nack),
        .tx_full    (tx_full),
        .tx_empty   (tx_empty),
        .rx_full    (rx_full),
        .rx_empty   (rx_empty),
        .rx_rdata   (rx_rdata),
        .prdata     (prdata),
        .pready     (pready),
        .prescale   (prescale),
        .slave_addr (slave_addr),
        .cmd        (cmd),
        .tx_push    (tx_push),
        .tx_wdata   (tx_wdata),
        .rx_pop     (rx_pop)
    );

    // CPU to bus bytes.
    i2c_fifo #(.fifo_aw(fifo_aw)) tx_fifo (
        .pclk  (pclk),
        .rst_n (rst_n),
        .flush (cmd.flush),
        .push  (tx_push),
        .wdata (tx_wdata),
        .pop   (tx_pop),
        .rdata (tx_rdata),
        .full  (tx_full),
        .empty (tx_empty)
    );

    // Bus to CPU bytes.
    i2c_fifo #(.fifo_aw(fifo_aw)) rx_fifo (
        .pclk  (pclk),
        .rst_n (rst_n),
        .flush (cmd.flush),
        .push  (rx_push),
        .wdata (rx_wdata),
        .pop   (rx_pop),
        .rdata (rx_rdata),
        .full  (rx_full),
        .empty (rx_empty)
    );

    i2c_scl_tick tick_gen (
        .pclk     (pclk),
        .rst_n    (rst_n),
        .run      (busy),
        .prescale (prescale),
        .tick     (tick)
    );

    i2c_master_ctrl ctrl (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .tick       (tick),
        .cmd        (cmd),
        .slave_addr (slave_addr),
        .tx_rdata   (tx_rdata),
        .tx_empty   (tx_empty),
        .rx_full    (rx_full),
        .sda_in     (sda_in),
        .tx_pop     (tx_pop),
        .rx_push    (rx_push),
        .rx_wdata   (rx_wdata),
        .busy       (busy),
        .nack       (nack),
        .scl_out    (scl_out),
        .sda_out    (sda_out)
    );

endmodule

// ==== tb_i2c_slave_model.sv ====
`timescale 1ns/1ns

module tb_i2c_slave_model #(
    parameter logic [6:0] dev_addr = 7'h2A
) (
    input  logic scl,
    input  logic sda,
    output logic sda_drive
);
    logic [7:0] wr_log [16];
    logic [7:0] rd_mem [16];
    int         wr_cnt = 0;
    int         rd_idx = 0;
    int         bit_n = 0;
    logic [7:0] shreg = 8'h00;
    logic [7:0] out_byte = 8'h00;
    logic       in_frame = 1'b0;
    logic       is_addr = 1'b0;
    logic       matched = 1'b0;
    logic       reading = 1'b0;
    logic       sending = 1'b0;
    logic       master_ack = 1'b0;

    initial sda_drive = 1'b1;

    // Start condition, SDA falls while SCL high.
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            in_frame = 1'b1;
            bit_n    = 0;
            is_addr  = 1'b1;
            matched  = 1'b0;
            reading  = 1'b0;
            sending  = 1'b0;
            wr_cnt   = 0;
            rd_idx   = 0;
        end
    end

    // Stop condition.
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            in_frame  = 1'b0;
            sending   = 1'b0;
            sda_drive = 1'b1;
        end
    end

    always @(posedge scl) begin
        if (in_frame) begin
            if (bit_n < 8) begin
                shreg = {shreg[6:0], sda};
                bit_n = bit_n + 1;
                if (bit_n == 8) begin
                    if (is_addr) begin
                        matched = (shreg[7:1] == dev_addr);
                        reading = shreg[0];
                    end
                    if (matched && (is_addr || !reading) && wr_cnt < 16) begin
                        wr_log[wr_cnt] = shreg;
                        wr_cnt = wr_cnt + 1;
                    end
                end
            end else begin
                master_ack = !sda;  // Ninth clock.
                bit_n      = 9;
            end
        end
    end

    always @(negedge scl) begin
        if (in_frame) begin
            if (bit_n == 8) begin
                if (sending)
                    sda_drive = 1'b1;  // Master owns the ACK slot.
                else if (matched)
                    sda_drive = 1'b0;
            end else if (bit_n == 9) begin
                bit_n   = 0;
                sending = matched && reading && (is_addr || master_ack);
                is_addr = 1'b0;
                if (sending) begin
                    out_byte = rd_mem[rd_idx];
                    rd_idx   = rd_idx + 1;
                end
                sda_drive = sending ? out_byte[7] : 1'b1;
            end else if (sending && bit_n > 0) begin
                sda_drive = out_byte[7 - bit_n];
            end
        end
    end

endmodule

// ==== i2c_master_chk.sv ====
`timescale 1ns/1ns

module i2c_master_chk (
    input logic pclk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic busy,
    input logic scl_out,
    input logic sda_out,
    input logic tx_push,
    input logic tx_pop,
    input logic tx_full,
    input logic flush
);
    int err_cnt = 0;

    a_pready: assert property (@(posedge pclk) disable iff (!rst_n)
        psel && penable |-> pready)
        else begin
            err_cnt++;
            $error("pready low in an APB access cycle");
        end

    // Bus released whenever the master is idle.
    a_idle_lines: assert property (@(posedge pclk) disable iff (!rst_n)
        !busy |-> scl_out && sda_out)
        else begin
            err_cnt++;
            $error("SCL or SDA driven low while idle");
        end

    // A push into a full TX FIFO must be dropped.
    a_tx_overflow: assert property (@(posedge pclk) disable iff (!rst_n)
        tx_push && tx_full && !tx_pop && !flush |=> tx_full)
        else begin
            err_cnt++;
            $error("TX FIFO level went past its depth");
        end

endmodule

bind i2c_master_top i2c_master_chk chk (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .busy    (busy),
    .scl_out (scl_out),
    .sda_out (sda_out),
    .tx_push (tx_push),
    .tx_pop  (tx_pop),
    .tx_full (tx_full),
    .flush   (cmd.flush)
);

// ==== tb_i2c_master.sv ====
`timescale 1ns/1ns

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int         reset_cycles  = 10;
    localparam int         test_prescale = 3;
    localparam logic [7:0] cnt_sel       = 8'hFF;  // Slave row selecting the byte count.

    typedef enum logic [1:0] {op_write, op_read, op_wait, op_slave} op_t;

    typedef struct packed {
        op_t        op;
        logic [7:0] off;
        logic [7:0] data;
        logic [7:0] exp;
    } row_t;

    logic        pclk = 1'b0;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [7:0]  pwdata;
    logic [7:0]  prdata;
    logic        pready;
    logic        scl_out;
    logic        sda_out;
    logic        sda_drive;
    wire         sda_line;
    row_t        rows[$];
    logic [7:0]  rd_bytes [16];
    logic [7:0]  rd;
    int unsigned cycles = 0;
    int unsigned limit = 0;

    assign sda_line = sda_out & sda_drive;  // Open-drain wire.

    i2c_master_top #(.fifo_aw(3)) uut (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .sda_in  (sda_line),
        .prdata  (prdata),
        .pready  (pready),
        .scl_out (scl_out),
        .sda_out (sda_out)
    );

    tb_i2c_slave_model #(.dev_addr(7'h2A)) slave (
        .scl       (scl_out),
        .sda       (sda_line),
        .sda_drive (sda_drive)
    );

    always #20 pclk = ~pclk;

    always @(posedge pclk) begin
        cycles <= cycles + 1;
        if (uut.chk.err_cnt != 0) begin
            $display("Checker reported %0d assertion failures.", uut.chk.err_cnt);
            abort_run();
        end else if (limit != 0 && cycles >= limit) begin
            $display("Timeout: no finish within %0d cycles.", limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input i2c_status_t got, input i2c_status_t exp);
        if (got !== exp) begin
            $display("[ERROR] status: got 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [7:0] status_byte(input logic busy, nack, tx_full, tx_empty,
                                               input logic rx_full, rx_empty);
        i2c_status_t s;
        s = '{busy: busy, nack: nack, tx_full: tx_full, tx_empty: tx_empty,
              rx_full: rx_full, rx_empty: rx_empty, rsvd: 2'b00};
        return s;
    endfunction

    function automatic logic [7:0] cmd_byte(input logic go, rw, flush, input logic [3:0] count);
        i2c_cmd_t c;
        c = '{go: go, rw: rw, flush: flush, count: count, rsvd: 1'b0};
        return c;
    endfunction

    task automatic add_row(input op_t op, input logic [7:0] off, input logic [7:0] data,
                           input logic [7:0] exp);
        rows.push_back(row_t'{op: op, off: off, data: data, exp: exp});
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge pclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge pclk);
        penable <= 1'b1;
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [7:0] data);
        @(posedge pclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge pclk);
        penable <= 1'b1;
        @(negedge pclk);
        data = prdata;  // Mid access cycle.
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Poll status until the transaction has ended.
    task automatic wait_idle();
        logic [7:0]  d;
        i2c_status_t st;
        apb_read(reg_status, d);
        st = i2c_status_t'(d);
        while (st.busy) begin
            apb_read(reg_status, d);
            st = i2c_status_t'(d);
        end
    endtask

    task automatic build_table();
        logic [7:0] idle_ok;
        idle_ok = status_byte(0, 0, 0, 1, 0, 1);
        add_row(op_read, reg_status, 8'h00, idle_ok);
        add_row(op_read, reg_prescale, 8'h00, 8'h00);
        add_row(op_read, reg_addr, 8'h00, 8'h00);
        add_row(op_write, reg_prescale, 8'(test_prescale), 8'h00);
        add_row(op_read, reg_prescale, 8'h00, 8'(test_prescale));
        add_row(op_write, reg_addr, 8'h2A, 8'h00);
        add_row(op_read, reg_addr, 8'h00, 8'h2A);
        // Write of three bytes.
        add_row(op_write, reg_txdata, 8'hA5, 8'h00);
        add_row(op_write, reg_txdata, 8'h3C, 8'h00);
        add_row(op_write, reg_txdata, 8'hF0, 8'h00);
        add_row(op_write, reg_cmd, cmd_byte(1, 0, 0, 4'd3), 8'h00);
        add_row(op_wait, 8'h00, 8'h00, 8'h00);
        add_row(op_slave, 8'd0, 8'h00, 8'h54);
        add_row(op_slave, 8'd1, 8'h00, 8'hA5);
        add_row(op_slave, 8'd2, 8'h00, 8'h3C);
        add_row(op_slave, 8'd3, 8'h00, 8'hF0);
        add_row(op_slave, cnt_sel, 8'h00, 8'd4);
        add_row(op_read, reg_status, 8'h00, idle_ok);
        // Read of four bytes.
        add_row(op_write, reg_cmd, cmd_byte(1, 1, 0, 4'd4), 8'h00);
        add_row(op_wait, 8'h00, 8'h00, 8'h00);
        for (int i = 0; i < 4; i++)
            add_row(op_read, reg_rxdata, 8'h00, rd_bytes[i]);
        add_row(op_read, reg_status, 8'h00, idle_ok);
        // Unknown address, then flush.
        add_row(op_write, reg_addr, 8'h11, 8'h00);
        add_row(op_write, reg_txdata, 8'h66, 8'h00);
        add_row(op_write, reg_txdata, 8'h99, 8'h00);
        add_row(op_write, reg_cmd, cmd_byte(1, 0, 0, 4'd2), 8'h00);
        add_row(op_wait, 8'h00, 8'h00, 8'h00);
        add_row(op_read, reg_status, 8'h00, status_byte(0, 1, 0, 0, 0, 1));
        add_row(op_write, reg_cmd, cmd_byte(0, 0, 1, 4'd0), 8'h00);
        add_row(op_read, reg_status, 8'h00, status_byte(0, 1, 0, 1, 0, 1));
        // Nine pushes into an eight deep FIFO.
        add_row(op_write, reg_addr, 8'h2A, 8'h00);
        for (int i = 0; i < 9; i++)
            add_row(op_write, reg_txdata, 8'(8'h11 * (i + 1)), 8'h00);
        add_row(op_read, reg_status, 8'h00, status_byte(0, 1, 1, 0, 0, 1));
        add_row(op_write, reg_cmd, cmd_byte(1, 0, 0, 4'd8), 8'h00);
        add_row(op_wait, 8'h00, 8'h00, 8'h00);
        add_row(op_slave, 8'd0, 8'h00, 8'h54);
        for (int i = 0; i < 8; i++)
            add_row(op_slave, 8'(i + 1), 8'h00, 8'(8'h11 * (i + 1)));
        add_row(op_slave, cnt_sel, 8'h00, 8'd9);
        add_row(op_read, reg_status, 8'h00, idle_ok);
    endtask

    initial begin
        void'($urandom(33));
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = 8'h00;
        foreach (rd_bytes[i])
            rd_bytes[i] = 8'($urandom);
        foreach (rd_bytes[i])
            slave.rd_mem[i] = rd_bytes[i];
        build_table();
        limit = rows.size() * 4 * (test_prescale + 1) * (9 * 16 + 11) + reset_cycles;

        repeat (reset_cycles) @(posedge pclk);
        rst_n <= 1'b1;
        @(negedge pclk);
        check_bit("scl_out", scl_out, 1'b1);
        check_bit("sda_out", sda_out, 1'b1);

        foreach (rows[i]) begin
            case (rows[i].op)
                op_write: apb_write(rows[i].off, rows[i].data);
                op_read: begin
                    apb_read(rows[i].off, rd);
                    if (rows[i].off == reg_status)
                        check_status(i2c_status_t'(rd), i2c_status_t'(rows[i].exp));
                    else
                        check_byte($sformatf("prdata@0x%h", rows[i].off), rd, rows[i].exp);
                end
                op_wait: wait_idle();
                default: begin
                    if (rows[i].off == cnt_sel)
                        check_byte("slave.wr_cnt", 8'(slave.wr_cnt), rows[i].exp);
                    else
                        check_byte($sformatf("slave.wr_log[%0d]", rows[i].off),
                                   slave.wr_log[rows[i].off], rows[i].exp);
                end
            endcase
        end

        if (uut.chk.err_cnt != 0) begin
            $display("Checker reported %0d assertion failures.", uut.chk.err_cnt);
            abort_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
i2c_pkg.sv
i2c_fifo.sv
i2c_scl_tick.sv
i2c_apb_regs.sv
i2c_master_ctrl.sv
i2c_master_top.sv
tb_i2c_slave_model.sv
i2c_master_chk.sv
tb_i2c_master.sv
